/* prefix_adder_top.f */
design/adder_arith_pkg.sv
design/adder_flow_pkg.sv
design/credit_gate.sv
design/prefix_front.sv
design/prefix_back.sv
design/prefix_adder_top.sv
test/tb_prefix_adder.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_prefix_adder
FILELIST  ?= prefix_adder_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "failure found in $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "run did not complete, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/prefix_adder_testdata.hex */
// columns: a b cin expected_sum expected_cout
// one operation per line, all values in hex
0000000000000000 0000000000000000 0 0000000000000000 0
0000000000000000 0000000000000000 1 0000000000000001 0
ffffffffffffffff 0000000000000000 1 0000000000000000 1
ffffffffffffffff ffffffffffffffff 0 fffffffffffffffe 1
ffffffffffffffff ffffffffffffffff 1 ffffffffffffffff 1
aaaaaaaaaaaaaaaa 5555555555555555 0 ffffffffffffffff 0
aaaaaaaaaaaaaaaa 5555555555555555 1 0000000000000000 1
aaaaaaaaaaaaaaaa aaaaaaaaaaaaaaaa 0 5555555555555554 1
5555555555555555 5555555555555555 1 aaaaaaaaaaaaaaab 0
0123456789abcdef fedcba9876543210 0 ffffffffffffffff 0
0123456789abcdef fedcba9876543210 1 0000000000000000 1
8000000000000000 8000000000000000 0 0000000000000000 1
7fffffffffffffff 0000000000000001 0 8000000000000000 0
123456789abcdef0 0fedcba987654321 0 2222222222222211 0
123456789abcdef0 0fedcba987654321 1 2222222222222212 0
deadbeefcafebabe 1111111111111111 0 efbed000dc0fcbcf 0
fedcba9876543210 fedcba9876543210 1 fdb97530eca86421 1
8000000000000001 ffffffffffffffff 0 8000000000000000 1

/* test/tb_prefix_adder.sv */
// Testbench for the pipelined prefix adder.
// Feeds operations from the testdata file, returns credits from an LFSR
// and checks every result, its latency and the credit back-pressure.

`default_nettype none

module tb_prefix_adder;

        timeunit 1ns;
        timeprecision 100ps;

        import adder_arith_pkg::*;
        import adder_flow_pkg::*;

        localparam int num_vectors = 18;
        localparam int words_per_vec = 5;

        logic clk = 1'b0;
        logic rst_n;
        add_req_t req;
        logic req_valid;
        logic req_ready;
        add_rsp_t rsp;
        logic rsp_valid;
        logic credit_return;

        logic [adder_width-1:0] vec_mem [0:num_vectors*words_per_vec-1];
        // cout in the top bit above the sum
        logic [adder_width:0] exp_q [$];
        int acc_q [$];
        logic [adder_width:0] cur_exp;

        int cycle_cnt;
        int feed_idx;
        int feed_limit;
        int accept_cnt;
        int rsp_cnt;
        int pending_credits;
        bit credit_lfsr_en;
        bit pulse_pending;
        logic [15:0] lfsr;
        int check_cnt;
        int value_errors;
        int other_errors;

        prefix_adder_top prefix_adder_top_inst (
                .clk           (clk),
                .rst_n         (rst_n),
                .req           (req),
                .req_valid     (req_valid),
                .req_ready     (req_ready),
                .rsp           (rsp),
                .rsp_valid     (rsp_valid),
                .credit_return (credit_return)
        );

        always #50 clk = ~clk;

        // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                logic [15:0] n;
                if (s[0]) begin
                        n = (s >> 1) ^ 16'hb400;
                end else begin
                        n = s >> 1;
                end
                return n;
        endfunction

        task automatic check_value(input string what, input logic [63:0] got,
                        input logic [63:0] expected);
                check_cnt++;
                if (got !== expected) begin
                        value_errors++;
                        $display("error: %s got 0x%h expected 0x%h at cycle %0d",
                                what, got, expected, cycle_cnt);
                end
        endtask

        // sample what the DUT saw at the edge and drive the next cycle
        task automatic step_cycle();
                logic [adder_width:0] exp_entry;
                int acc_cycle;
                int v;
                logic credit_next;
                @(posedge clk);
                cycle_cnt++;
                if (rst_n && req_valid && req_ready) begin
                        exp_q.push_back(cur_exp);
                        acc_q.push_back(cycle_cnt);
                        accept_cnt++;
                        feed_idx++;
                end
                if (rst_n && rsp_valid) begin
                        rsp_cnt++;
                        pending_credits++;
                        if (exp_q.size() == 0) begin
                                $display("result arrived with no operation outstanding at cycle %0d",
                                        cycle_cnt);
                                other_errors++;
                        end else begin
                                exp_entry = exp_q.pop_front();
                                acc_cycle = acc_q.pop_front();
                                check_value("rsp.sum", rsp.sum, exp_entry[adder_width-1:0]);
                                check_value("rsp.cout", 64'(rsp.cout), 64'(exp_entry[adder_width]));
                                check_value("rsp latency", 64'(cycle_cnt - acc_cycle), 64'd2);
                        end
                end
                // never return more slots than results received
                credit_next = 1'b0;
                if (pulse_pending && pending_credits > 0) begin
                        credit_next = 1'b1;
                        pulse_pending = 1'b0;
                end else if (credit_lfsr_en && pending_credits > 0) begin
                        lfsr = lfsr_step(lfsr);
                        credit_next = lfsr[0];
                end
                if (credit_next) begin
                        pending_credits--;
                end
                credit_return <= credit_next;
                if (feed_idx < feed_limit) begin
                        v = (feed_idx % num_vectors) * words_per_vec;
                        req.a <= vec_mem[v];
                        req.b <= vec_mem[v+1];
                        req.cin <= vec_mem[v+2][0];
                        cur_exp <= {vec_mem[v+4][0], vec_mem[v+3]};
                        req_valid <= 1'b1;
                end else begin
                        req_valid <= 1'b0;
                end
        endtask

        initial begin
                int timeout;
                int base_acc;
                int base_rsp;
                rst_n = 1'b0;
                req = '0;
                req_valid = 1'b0;
                credit_return = 1'b0;
                cur_exp = '0;
                cycle_cnt = 0;
                feed_idx = 0;
                feed_limit = 0;
                accept_cnt = 0;
                rsp_cnt = 0;
                pending_credits = 0;
                credit_lfsr_en = 1'b0;
                pulse_pending = 1'b0;
                lfsr = 16'd71;
                check_cnt = 0;
                value_errors = 0;
                other_errors = 0;
                $readmemh("test/prefix_adder_testdata.hex", vec_mem);

                repeat (4) step_cycle();
                rst_n <= 1'b1;
                step_cycle();
                check_value("rsp_valid", 64'(rsp_valid), 64'd0);
                check_value("req_ready", 64'(req_ready), 64'd1);

                // all vectors while credits trickle back at random
                credit_lfsr_en = 1'b1;
                feed_limit = num_vectors;
                timeout = 0;
                while (rsp_cnt < num_vectors && timeout < 1000) begin
                        step_cycle();
                        timeout++;
                end
                if (rsp_cnt < num_vectors) begin
                        $display("timed out waiting for results, got %0d of %0d",
                                rsp_cnt, num_vectors);
                        other_errors++;
                end

                timeout = 0;
                while (pending_credits > 0 && timeout < 200) begin
                        step_cycle();
                        timeout++;
                end
                if (pending_credits > 0) begin
                        $display("timed out returning credits, %0d still held", pending_credits);
                        other_errors++;
                end
                credit_lfsr_en = 1'b0;
                step_cycle();

                // sink keeps every slot so the gate closes after credit_depth accepts
                base_acc = accept_cnt;
                base_rsp = rsp_cnt;
                feed_limit = feed_idx + 2 * credit_depth;
                timeout = 0;
                while (req_ready && timeout < 50) begin
                        step_cycle();
                        timeout++;
                end
                if (req_ready) begin
                        $display("timed out waiting for req_ready to fall");
                        other_errors++;
                end
                check_value("accepts before stall", 64'(accept_cnt - base_acc), 64'(credit_depth));
                timeout = 0;
                while (rsp_cnt - base_rsp < credit_depth && timeout < 50) begin
                        step_cycle();
                        timeout++;
                end
                // quiet window where nothing more may come out
                for (int i = 0; i < 6; i++) begin
                        step_cycle();
                end
                check_value("results while stalled", 64'(rsp_cnt - base_rsp), 64'(credit_depth));
                check_value("accepts while stalled", 64'(accept_cnt - base_acc), 64'(credit_depth));
                check_value("req_ready", 64'(req_ready), 64'd0);

                // one returned slot buys exactly one more operation
                base_acc = accept_cnt;
                pulse_pending = 1'b1;
                for (int i = 0; i < 8; i++) begin
                        step_cycle();
                end
                check_value("accepts after one credit", 64'(accept_cnt - base_acc), 64'd1);
                check_value("req_ready", 64'(req_ready), 64'd0);

                feed_limit = feed_idx;
                timeout = 0;
                while (exp_q.size() > 0 && timeout < 50) begin
                        step_cycle();
                        timeout++;
                end
                if (exp_q.size() > 0) begin
                        $display("timed out with %0d results still outstanding", exp_q.size());
                        other_errors++;
                end

                $display("checks %0d, value errors %0d, other errors %0d",
                        check_cnt, value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* design/prefix_adder_top.sv */
// Top level of the pipelined 64-bit prefix adder.
// One operation per cycle, result two cycles after acceptance, with
// credit-based flow control on the result port. Connects the credit
// gate and the two prefix stages.

`default_nettype none

module prefix_adder_top (
        input  logic                      clk,
        input  logic                      rst_n,
        input  adder_flow_pkg::add_req_t  req,
        input  logic                      req_valid,
        output logic                      req_ready,
        output adder_flow_pkg::add_rsp_t  rsp,
        output logic                      rsp_valid,
        input  logic                      credit_return
);

        import adder_arith_pkg::*;

        logic accept;
        stage_t stage;

        assign accept = req_valid & req_ready;

        credit_gate credit_gate_inst (
                .clk           (clk),
                .rst_n         (rst_n),
                .req_valid     (req_valid),
                .credit_return (credit_return),
                .req_ready     (req_ready)
        );

        prefix_front prefix_front_inst (
                .clk    (clk),
                .rst_n  (rst_n),
                .req    (req),
                .accept (accept),
                .stage  (stage)
        );

        prefix_back prefix_back_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .stage     (stage),
                .rsp       (rsp),
                .rsp_valid (rsp_valid)
        );

endmodule

`default_nettype wire

/* design/prefix_back.sv */
// Second stage of the pipelined prefix adder.
// Finishes the upper Sklansky levels on the registered groups, builds
// the sum from the raw propagate bits and the carries into each
// position, and registers the result for the sink.

`default_nettype none

module prefix_back (
        input  logic                      clk,
        input  logic                      rst_n,
        input  adder_arith_pkg::stage_t   stage,
        output adder_flow_pkg::add_rsp_t  rsp,
        output logic                      rsp_valid
);

        import adder_arith_pkg::*;
        import adder_flow_pkg::*;

        pg_vec_t pg_fin;
        add_rsp_t rsp_d;

        always_comb begin
                pg_fin = stage.pg;
                for (int k = front_levels + 1; k <= prefix_levels; k++) begin
                        pg_fin = prefix_level(pg_fin, k);
                end
        end

        // carry into bit i is the group generate of position i-1
        always_comb begin
                rsp_d.sum = stage.prop ^ pg_fin.g[adder_width-1:0];
                // top position never combines and still holds the raw p/g
                rsp_d.cout = pg_fin.g[adder_width] |
                        (pg_fin.p[adder_width] & pg_fin.g[adder_width-1]);
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        rsp_valid <= 1'b0;
                end else begin
                        rsp_valid <= stage.valid;
                end
                if (stage.valid) begin
                        rsp <= rsp_d;
                end
        end

        // a result never leaves with unknown bits
        a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
                rsp_valid |-> !$isunknown(rsp));

endmodule

`default_nettype wire

/* design/prefix_front.sv */
// First stage of the pipelined prefix adder.
// Forms propagate/generate with cin injected at position zero, runs
// the lower Sklansky levels and registers the partial groups together
// with the raw propagate bits needed later for the sum.

`default_nettype none

module prefix_front (
        input  logic                      clk,
        input  logic                      rst_n,
        input  adder_flow_pkg::add_req_t  req,
        input  logic                      accept,
        output adder_arith_pkg::stage_t   stage
);

        import adder_arith_pkg::*;

        pg_vec_t pg_in;
        pg_vec_t pg_mid;

        always_comb begin
                pg_in.p = {req.a ^ req.b, 1'b0};
                pg_in.g = {req.a & req.b, req.cin};
        end

        always_comb begin
                pg_mid = pg_in;
                for (int k = 1; k <= front_levels; k++) begin
                        pg_mid = prefix_level(pg_mid, k);
                end
        end

        // payload only loads on accept, valid follows accept
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        stage.valid <= 1'b0;
                end else begin
                        stage.valid <= accept;
                end
                if (accept) begin
                        stage.pg <= pg_mid;
                        stage.prop <= pg_in.p[adder_width:1];
                end
        end

endmodule

`default_nettype wire

/* design/credit_gate.sv */
// Credit counter in front of the adder pipeline.
// A credit is spent on every accepted operation and given back by a
// credit_return pulse from the sink. New operations enter only while
// at least one credit is held.

`default_nettype none

module credit_gate (
        input  logic clk,
        input  logic rst_n,
        input  logic req_valid,
        input  logic credit_return,
        output logic req_ready
);

        import adder_flow_pkg::*;

        credit_cnt_t credit_cnt;
        logic accept;

        assign accept = req_valid & req_ready;
        assign req_ready = (credit_cnt != '0);

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        credit_cnt <= credit_cnt_t'(credit_depth);
                end else begin
                        case ({accept, credit_return})
                                2'b10: credit_cnt <= credit_cnt - 1'b1;
                                2'b01: credit_cnt <= credit_cnt + 1'b1;
                                // both or neither leave the count alone
                                default: credit_cnt <= credit_cnt;
                        endcase
                end
        end

        // sink returned a slot it was never given
        a_no_return_when_full: assert property (@(posedge clk) disable iff (!rst_n)
                credit_return |-> credit_cnt != credit_cnt_t'(credit_depth));

        a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
                credit_cnt <= credit_cnt_t'(credit_depth));

endmodule

`default_nettype wire

/* design/adder_flow_pkg.sv */
// Transport definitions for the prefix adder ports.
// Request and result structs plus the credit depth granted to the
// result sink after reset.

`default_nettype none

package adder_flow_pkg;

        localparam int credit_depth = 4;

        // must hold 0 .. credit_depth
        typedef logic [$clog2(credit_depth + 1)-1:0] credit_cnt_t;

        typedef struct packed {
                logic [adder_arith_pkg::adder_width-1:0] a;
                logic [adder_arith_pkg::adder_width-1:0] b;
                logic cin;
        } add_req_t;

        typedef struct packed {
                logic [adder_arith_pkg::adder_width-1:0] sum;
                logic cout;
        } add_rsp_t;

endpackage

`default_nettype wire

/* design/adder_arith_pkg.sv */
// Arithmetic definitions for the pipelined 64-bit prefix adder.
// Holds the operand width, the prefix level counts, the packed
// propagate/generate vector and the Sklansky level function used by
// both pipeline stages of the prefix network.

`default_nettype none

package adder_arith_pkg;

        localparam int adder_width = 64;
        localparam int prefix_levels = $clog2(adder_width);
        // levels done before the first pipeline register
        localparam int front_levels = 3;

        // index zero holds cin as generate, zero as propagate
        typedef struct packed {
                logic [adder_width:0] p;
                logic [adder_width:0] g;
        } pg_vec_t;

        // front-to-back pipeline register contents
        typedef struct packed {
                pg_vec_t pg;
                logic [adder_width:1] prop;
                logic valid;
        } stage_t;

        // one Sklansky level
        // positions with bit k-1 set take in the last position of the
        // block just below them, the rest pass through
        function automatic pg_vec_t prefix_level(input pg_vec_t v, input int unsigned k);
                pg_vec_t r;
                int unsigned j;
                r = v;
                for (int unsigned i = 0; i <= adder_width; i++) begin
                        if (((i >> (k - 1)) & 1) != 0) begin
                                j = ((i >> (k - 1)) << (k - 1)) - 1;
                                r.g[i] = v.g[i] | (v.p[i] & v.g[j]);
                                r.p[i] = v.p[i] & v.p[j];
                        end
                end
                return r;
        endfunction

endpackage

`default_nettype wire
